// ==== logic/alu_ops_pkg.sv ====
// ----------------------------------------------------------
// Shared widths, encodings and payload structs for the ALU-ops
// configuration collector; referenced as alu_ops_pkg::name
// ----------------------------------------------------------
package alu_ops_pkg;

    // Memory packet layout
    localparam int MEM_DATA_W   = 32;
    localparam int MEM_OFFSET_W = 16;
    localparam int MEM_SHIFT_W  = 4;

    // Sequence window per engine, also the length of one setup run
    localparam int ENGINE_SEQ_WIDTH = 16;

    // ALU lane data fields
    localparam int NUM_FIELDS = 4;
    localparam int ALU_OP_W   = 3;

    // Routing IDs
    localparam int MODULE_ID_W = 2;
    localparam int ENGINE_ID_W = 2;
    localparam int CU_ID_W     = 2;
    localparam int BUNDLE_ID_W = 2;
    localparam int LANE_ID_W   = 2;
    localparam int BUFFER_ID_W = 3;

    // FIFO sizing
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;

    typedef enum logic [1:0] {
        STRUCT_INVALID      = 2'd0,
        STRUCT_CU_SETUP     = 2'd1,
        STRUCT_ENGINE_SETUP = 2'd2,
        STRUCT_OTHER        = 2'd3
    } buffer_kind_t;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_NOP = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_MUL = 3'd3,
        ALU_ACC = 3'd4,
        ALU_DIV = 3'd5,
        ALU_GT  = 3'd6,
        ALU_EQ  = 3'd7
    } alu_operation_t;

    typedef struct packed {
        buffer_kind_t            buffer;
        logic [MEM_OFFSET_W-1:0] offset;
        logic [MEM_SHIFT_W-1:0]  shift;
        logic [MEM_DATA_W-1:0]   data;
    } response_payload_t;

    typedef struct packed {
        alu_operation_t                     alu_operation;
        logic [NUM_FIELDS-1:0]              alu_mask;
        logic [NUM_FIELDS-1:0]              const_mask;
        logic [MEM_DATA_W-1:0]              const_value;
        logic [NUM_FIELDS*NUM_FIELDS-1:0]   ops_mask;
        logic [MODULE_ID_W-1:0]             to_module;
        logic [ENGINE_ID_W-1:0]             to_engine;
        logic [CU_ID_W-1:0]                 to_cu;
        logic [BUNDLE_ID_W-1:0]             to_bundle;
        logic [LANE_ID_W-1:0]               to_lane;
        logic [BUFFER_ID_W-1:0]             to_buffer;
    } alu_ops_config_t;

    // Sequence index of a packet, offset scaled down by its shift
    function automatic logic [MEM_OFFSET_W-1:0] seq_index(
        input logic [MEM_OFFSET_W-1:0] offset,
        input logic [MEM_SHIFT_W-1:0]  shift
    );
        return offset >> shift;
    endfunction

endpackage : alu_ops_pkg

// ==== logic/sync_fifo.sv ====
// ----------------------------------------------------------
// Single-clock FIFO for any packed payload type, with a
// programmable-full flag and a read valid one cycle after pop
// ----------------------------------------------------------
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     ap_clk,
    input  logic     areset_alu_ops_generator,
    input  logic     push,
    input  payload_t push_payload,
    input  logic     pop,
    output payload_t rd_payload,
    output logic     rd_valid,
    output logic     empty,
    output logic     prog_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_accept;
    logic             rd_accept;

    // Writes when full and reads when empty are dropped
    assign wr_accept = push & (count != CNT_W'(DEPTH));
    assign rd_accept = pop & (count != '0);

    assign empty     = (count == '0);
    assign prog_full = (count >= CNT_W'(alu_ops_pkg::PROG_THRESH));

    // ----------------------------------------------------------
    // Pointers, occupancy and read strobe
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_accept;
            if (wr_accept) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_accept, rd_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= push_payload;
        end
        if (rd_accept) begin
            rd_payload <= mem[rd_ptr];
        end
    end

endmodule : sync_fifo

// ==== logic/config_response_filter.sv ====
// ----------------------------------------------------------
// Input stage: registers response packets and pushes only the
// setup words that fall in this engine's sequence window
// ----------------------------------------------------------
`timescale 1ns/10ps

module config_response_filter #(
    parameter int ID_RELATIVE = 0
) (
    input  logic                                  ap_clk,
    input  logic                                  areset_alu_ops_generator,
    input  logic                                  response_in_valid,
    input  alu_ops_pkg::buffer_kind_t             response_in_buffer,
    input  logic [alu_ops_pkg::MEM_OFFSET_W-1:0]  response_in_offset,
    input  logic [alu_ops_pkg::MEM_SHIFT_W-1:0]   response_in_shift,
    input  logic [alu_ops_pkg::MEM_DATA_W-1:0]    response_in_data,
    output logic                                  push,
    output alu_ops_pkg::response_payload_t        push_payload
);

    localparam int OFF_W = alu_ops_pkg::MEM_OFFSET_W;
    localparam logic [OFF_W-1:0] SEQ_MIN = OFF_W'(ID_RELATIVE * alu_ops_pkg::ENGINE_SEQ_WIDTH);
    localparam logic [OFF_W-1:0] SEQ_MAX = OFF_W'(SEQ_MIN + alu_ops_pkg::ENGINE_SEQ_WIDTH);

    logic                           valid_reg;
    alu_ops_pkg::response_payload_t packet_reg;
    logic [OFF_W-1:0]               seq_idx;
    logic                           is_setup;
    logic                           in_window;

    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            valid_reg <= 1'b0;
        end else begin
            valid_reg <= response_in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        packet_reg.buffer <= response_in_buffer;
        packet_reg.offset <= response_in_offset;
        packet_reg.shift  <= response_in_shift;
        packet_reg.data   <= response_in_data;
    end

    // Window check on the registered copy
    assign seq_idx   = alu_ops_pkg::seq_index(packet_reg.offset, packet_reg.shift);
    assign is_setup  = (packet_reg.buffer == alu_ops_pkg::STRUCT_CU_SETUP) |
                       (packet_reg.buffer == alu_ops_pkg::STRUCT_ENGINE_SETUP);
    assign in_window = (seq_idx >= SEQ_MIN) & (seq_idx < SEQ_MAX);

    assign push         = valid_reg & is_setup & in_window;
    assign push_payload = packet_reg;

endmodule : config_response_filter

// ==== logic/alu_ops_sequence_assembler.sv ====
// ----------------------------------------------------------
// Pops queued setup words, tracks a 16-word run and decodes the
// first six words into one ALU-ops configuration
// ----------------------------------------------------------
`timescale 1ns/10ps

module alu_ops_sequence_assembler #(
    parameter int ID_RELATIVE = 0
) (
    input  logic                           ap_clk,
    input  logic                           areset_alu_ops_generator,
    input  logic                           fifo_empty,
    input  logic                           fifo_rd_valid,
    input  alu_ops_pkg::response_payload_t fifo_rd_payload,
    input  logic                           response_drain_en,
    input  logic                           config_prog_full,
    output logic                           pop,
    output logic                           config_valid,
    output alu_ops_pkg::alu_ops_config_t   alu_config
);

    localparam int RUN_W = alu_ops_pkg::ENGINE_SEQ_WIDTH;
    localparam int OFF_W = alu_ops_pkg::MEM_OFFSET_W;
    localparam int NF    = alu_ops_pkg::NUM_FIELDS;
    localparam logic [OFF_W-1:0] SEQ_MIN = OFF_W'(ID_RELATIVE * RUN_W);

    // Bit offsets inside the routing words
    localparam int ENG_LSB = NF + alu_ops_pkg::MODULE_ID_W;
    localparam int BND_LSB = alu_ops_pkg::CU_ID_W;
    localparam int LAN_LSB = BND_LSB + alu_ops_pkg::BUNDLE_ID_W;
    localparam int BUF_LSB = LAN_LSB + alu_ops_pkg::LANE_ID_W;

    logic [RUN_W-1:0]               tracker;
    logic                           word_valid;
    alu_ops_pkg::response_payload_t word_reg;
    logic [OFF_W-1:0]               rd_seq_idx;
    logic                           last_word_seen;
    logic                           emit;

    assign rd_seq_idx = alu_ops_pkg::seq_index(fifo_rd_payload.offset, fifo_rd_payload.shift);

    // Sixteenth word arriving now, then the emit cycle after it
    assign last_word_seen = fifo_rd_valid & tracker[RUN_W-2];
    assign emit           = word_valid & tracker[RUN_W-1];

    assign pop = ~fifo_empty & response_drain_en & ~last_word_seen & ~emit & ~config_prog_full;

    // ----------------------------------------------------------
    // Run tracker
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            tracker      <= '0;
            word_valid   <= 1'b0;
            config_valid <= 1'b0;
        end else begin
            word_valid   <= fifo_rd_valid;
            config_valid <= emit;
            if (fifo_rd_valid) begin
                if ((rd_seq_idx == SEQ_MIN) && (tracker == '0)) begin
                    tracker <= RUN_W'(1);
                end else begin
                    // Empty tracker stays empty, stray words are dropped
                    tracker <= tracker << 1;
                end
            end else if (emit) begin
                tracker <= '0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        word_reg <= fifo_rd_payload;
    end

    // ----------------------------------------------------------
    // Field decode by run position
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (word_valid) begin
            case (tracker)
                RUN_W'(1 << 0): begin
                    alu_config.alu_operation <=
                        alu_ops_pkg::alu_operation_t'(word_reg.data[alu_ops_pkg::ALU_OP_W-1:0]);
                end
                RUN_W'(1 << 1): begin
                    alu_config.alu_mask  <= word_reg.data[NF-1:0];
                    alu_config.to_module <= word_reg.data[NF +: alu_ops_pkg::MODULE_ID_W];
                    alu_config.to_engine <= word_reg.data[ENG_LSB +: alu_ops_pkg::ENGINE_ID_W];
                end
                RUN_W'(1 << 2): begin
                    alu_config.const_mask <= word_reg.data[NF-1:0];
                end
                RUN_W'(1 << 3): begin
                    alu_config.const_value <= word_reg.data;
                end
                RUN_W'(1 << 4): begin
                    alu_config.ops_mask <= word_reg.data[NF*NF-1:0];
                end
                RUN_W'(1 << 5): begin
                    alu_config.to_cu     <= word_reg.data[0 +: alu_ops_pkg::CU_ID_W];
                    alu_config.to_bundle <= word_reg.data[BND_LSB +: alu_ops_pkg::BUNDLE_ID_W];
                    alu_config.to_lane   <= word_reg.data[LAN_LSB +: alu_ops_pkg::LANE_ID_W];
                    alu_config.to_buffer <= word_reg.data[BUF_LSB +: alu_ops_pkg::BUFFER_ID_W];
                end
                // Words 6 to 15 carry nothing
                default: begin
                end
            endcase
        end
    end

endmodule : alu_ops_sequence_assembler

// ==== logic/engine_alu_ops_configure_memory.sv ====
// ----------------------------------------------------------
// ALU-ops configuration collector top: filter, response FIFO,
// sequence assembler and configuration FIFO in a chain
// ----------------------------------------------------------
`timescale 1ns/10ps

module engine_alu_ops_configure_memory #(
    parameter int ID_RELATIVE = 0
) (
    input  logic                                  ap_clk,
    input  logic                                  areset_alu_ops_generator,
    input  logic                                  response_in_valid,
    input  alu_ops_pkg::buffer_kind_t             response_in_buffer,
    input  logic [alu_ops_pkg::MEM_OFFSET_W-1:0]  response_in_offset,
    input  logic [alu_ops_pkg::MEM_SHIFT_W-1:0]   response_in_shift,
    input  logic [alu_ops_pkg::MEM_DATA_W-1:0]    response_in_data,
    input  logic                                  response_drain_en,
    input  logic                                  config_ready,
    output logic                                  config_out_valid,
    output alu_ops_pkg::alu_ops_config_t          config_out
);

    // ----------------------------------------------------------
    // Internal nets
    // ----------------------------------------------------------
    logic                           resp_push;
    alu_ops_pkg::response_payload_t resp_push_payload;
    logic                           resp_pop;
    alu_ops_pkg::response_payload_t resp_rd_payload;
    logic                           resp_rd_valid;
    logic                           resp_empty;

    logic                           cfg_push;
    alu_ops_pkg::alu_ops_config_t   cfg_push_payload;
    logic                           cfg_pop;
    logic                           cfg_empty;
    logic                           cfg_prog_full;

    config_response_filter #(
        .ID_RELATIVE(ID_RELATIVE)
    ) u_filter (
        .ap_clk                  (ap_clk),
        .areset_alu_ops_generator(areset_alu_ops_generator),
        .response_in_valid       (response_in_valid),
        .response_in_buffer      (response_in_buffer),
        .response_in_offset      (response_in_offset),
        .response_in_shift       (response_in_shift),
        .response_in_data        (response_in_data),
        .push                    (resp_push),
        .push_payload            (resp_push_payload)
    );

    sync_fifo #(
        .payload_t(alu_ops_pkg::response_payload_t),
        .DEPTH    (alu_ops_pkg::FIFO_DEPTH)
    ) u_response_fifo (
        .ap_clk                  (ap_clk),
        .areset_alu_ops_generator(areset_alu_ops_generator),
        .push                    (resp_push),
        .push_payload            (resp_push_payload),
        .pop                     (resp_pop),
        .rd_payload              (resp_rd_payload),
        .rd_valid                (resp_rd_valid),
        .empty                   (resp_empty),
        .prog_full               ()
    );

    alu_ops_sequence_assembler #(
        .ID_RELATIVE(ID_RELATIVE)
    ) u_assembler (
        .ap_clk                  (ap_clk),
        .areset_alu_ops_generator(areset_alu_ops_generator),
        .fifo_empty              (resp_empty),
        .fifo_rd_valid           (resp_rd_valid),
        .fifo_rd_payload         (resp_rd_payload),
        .response_drain_en       (response_drain_en),
        .config_prog_full        (cfg_prog_full),
        .pop                     (resp_pop),
        .config_valid            (cfg_push),
        .alu_config              (cfg_push_payload)
    );

    // Drain finished configurations while the consumer is ready
    assign cfg_pop = ~cfg_empty & config_ready;

    sync_fifo #(
        .payload_t(alu_ops_pkg::alu_ops_config_t),
        .DEPTH    (alu_ops_pkg::FIFO_DEPTH)
    ) u_config_fifo (
        .ap_clk                  (ap_clk),
        .areset_alu_ops_generator(areset_alu_ops_generator),
        .push                    (cfg_push),
        .push_payload            (cfg_push_payload),
        .pop                     (cfg_pop),
        .rd_payload              (config_out),
        .rd_valid                (config_out_valid),
        .empty                   (cfg_empty),
        .prog_full               (cfg_prog_full)
    );

endmodule : engine_alu_ops_configure_memory

// ==== sim/tb_clock_gen.sv ====
// ----------------------------------------------------------
// Testbench clock (100 ns) and synchronous reset held 8 cycles
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_clock_gen (
    output logic ap_clk,
    output logic areset_alu_ops_generator
);

    localparam int PERIOD_NS    = 100;
    localparam int RESET_CYCLES = 8;

    initial begin
        ap_clk = 1'b0;
        forever #(PERIOD_NS / 2) ap_clk = ~ap_clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        areset_alu_ops_generator = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_alu_ops_generator = 1'b0;
    end

endmodule : tb_clock_gen

// ==== sim/tb_config_checker.sv ====
// ----------------------------------------------------------
// Scoreboard for the collector output; compares each emitted
// configuration with the next entry of the expected list
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_config_checker (
    input logic                         ap_clk,
    input logic                         areset_alu_ops_generator,
    input logic                         config_out_valid,
    input alu_ops_pkg::alu_ops_config_t config_out
);

    alu_ops_pkg::alu_ops_config_t expected_q [$];
    string                        name_q [$];

    int expected_total;
    int seen_count;
    int mismatch_count;
    int extra_count;
    int missing_count;
    int reset_count;
    int error_total;

    task automatic add_expected(input string name, input alu_ops_pkg::alu_ops_config_t cfg);
        name_q.push_back(name);
        expected_q.push_back(cfg);
        expected_total++;
    endtask

    // Outputs only move on the rising edge, so look on the falling one
    always @(negedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            if (config_out_valid !== 1'b0) begin
                reset_count++;
                $display("Error: config_out_valid is not low during reset at %0t", $time);
            end
        end else if (config_out_valid === 1'b1) begin
            seen_count++;
            if (expected_q.size() == 0) begin
                extra_count++;
                $display("Error: extra configuration %h appeared with no entry left to match",
                         config_out);
            end else begin
                if (config_out !== expected_q[0]) begin
                    mismatch_count++;
                    $display("[FAIL] %0s expected %h actual %h",
                             name_q[0], expected_q[0], config_out);
                end
                expected_q.delete(0);
                name_q.delete(0);
            end
        end
    end

    // ----------------------------------------------------------
    // Closing summary
    // ----------------------------------------------------------
    task automatic report(input int vector_errors);
        missing_count = expected_q.size();
        if (missing_count != 0) begin
            $display("Error: %0d expected configurations never appeared, first one is %0s",
                     missing_count, name_q[0]);
        end
        error_total = mismatch_count + extra_count + missing_count + reset_count;
        $display({"Summary: seen %0d of %0d, mismatch %0d, missing %0d, extra %0d, ",
                  "reset %0d, vector file %0d"},
                 seen_count, expected_total, mismatch_count, missing_count, extra_count,
                 reset_count, vector_errors);
    endtask

endmodule : tb_config_checker

// ==== sim/tb_engine_alu_ops_configure_memory.sv ====
// ----------------------------------------------------------
// Testbench top: replays the vector file into the collector on
// falling edges and feeds the expected list to the checker
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_engine_alu_ops_configure_memory;

    localparam int ID_RELATIVE     = 1;
    localparam int WINDOW_START    = ID_RELATIVE * alu_ops_pkg::ENGINE_SEQ_WIDTH;
    localparam int LINE_BYTES      = 200;
    localparam int CYCLES_PER_LINE = 200;
    localparam int BASE_CYCLES     = 1000;
    localparam int SETTLE_CYCLES   = 50;

    logic                                 ap_clk;
    logic                                 areset_alu_ops_generator;
    logic                                 response_in_valid;
    alu_ops_pkg::buffer_kind_t            response_in_buffer;
    logic [alu_ops_pkg::MEM_OFFSET_W-1:0] response_in_offset;
    logic [alu_ops_pkg::MEM_SHIFT_W-1:0]  response_in_shift;
    logic [alu_ops_pkg::MEM_DATA_W-1:0]   response_in_data;
    logic                                 response_drain_en;
    logic                                 config_ready;
    logic                                 config_out_valid;
    alu_ops_pkg::alu_ops_config_t         config_out;

    logic [8*LINE_BYTES-1:0] lines [$];
    logic [31:0]             run_words [6];
    integer                  seed;
    int                      watchdog_cycles;
    int                      vector_errors;
    int                      expects_passed;

    tb_clock_gen u_clock (
        .ap_clk                  (ap_clk),
        .areset_alu_ops_generator(areset_alu_ops_generator)
    );

    engine_alu_ops_configure_memory #(
        .ID_RELATIVE(ID_RELATIVE)
    ) u_dut (
        .ap_clk                  (ap_clk),
        .areset_alu_ops_generator(areset_alu_ops_generator),
        .response_in_valid       (response_in_valid),
        .response_in_buffer      (response_in_buffer),
        .response_in_offset      (response_in_offset),
        .response_in_shift       (response_in_shift),
        .response_in_data        (response_in_data),
        .response_drain_en       (response_drain_en),
        .config_ready            (config_ready),
        .config_out_valid        (config_out_valid),
        .config_out              (config_out)
    );

    tb_config_checker u_checker (
        .ap_clk                  (ap_clk),
        .areset_alu_ops_generator(areset_alu_ops_generator),
        .config_out_valid        (config_out_valid),
        .config_out              (config_out)
    );

    task automatic load_vectors();
        int                      fd;
        logic [8*LINE_BYTES-1:0] raw;
        fd = $fopen("sim/alu_ops_vectors.txt", "r");
        if (fd == 0) begin
            $display("Error: the vector file could not be opened");
            vector_errors++;
        end else begin
            while (!$feof(fd)) begin
                raw = '0;
                if ($fgets(raw, fd) != 0) begin
                    lines.push_back(raw);
                end
            end
            $fclose(fd);
        end
    endtask

    // First non-blank character, comments and blank lines read as #
    function automatic logic [7:0] line_tag(input logic [8*LINE_BYTES-1:0] raw);
        logic [7:0] tag;
        if ($sscanf(raw, " %c", tag) != 1) begin
            tag = "#";
        end
        return tag;
    endfunction

    task automatic register_expect(input logic [8*LINE_BYTES-1:0] raw);
        logic [7:0]                   tag;
        string                        name;
        logic [31:0]                  f [11];
        alu_ops_pkg::alu_ops_config_t cfg;
        if ($sscanf(raw, " %c %s %h %h %h %h %h %h %h %h %h %h %h", tag, name, f[0], f[1],
                    f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]) != 13) begin
            $display("Error: an expect line in the vector file is malformed");
            vector_errors++;
        end else begin
            cfg.alu_operation = alu_ops_pkg::alu_operation_t'(f[0][2:0]);
            cfg.alu_mask      = f[1][3:0];
            cfg.const_mask    = f[2][3:0];
            cfg.const_value   = f[3];
            cfg.ops_mask      = f[4][15:0];
            cfg.to_module     = f[5][1:0];
            cfg.to_engine     = f[6][1:0];
            cfg.to_cu         = f[7][1:0];
            cfg.to_bundle     = f[8][1:0];
            cfg.to_lane       = f[9][1:0];
            cfg.to_buffer     = f[10][2:0];
            u_checker.add_expected(name, cfg);
        end
    endtask

    // One packet, then 0 to 3 idle cycles
    task automatic drive_packet(input logic [1:0] kind, input logic [15:0] offset,
                                input logic [3:0] shift, input logic [31:0] data);
        int idle;
        @(negedge ap_clk);
        response_in_valid  = 1'b1;
        response_in_buffer = alu_ops_pkg::buffer_kind_t'(kind);
        response_in_offset = offset;
        response_in_shift  = shift;
        response_in_data   = data;
        idle = $unsigned($random(seed)) % 4;
        if (idle != 0) begin
            @(negedge ap_clk);
            response_in_valid = 1'b0;
            repeat (idle - 1) @(negedge ap_clk);
        end
    endtask

    task automatic release_bus();
        @(negedge ap_clk);
        response_in_valid = 1'b0;
    endtask

    // Run positions first..first+count-1; words 6 to 15 get filler data
    task automatic send_run(input logic [1:0] kind, input logic [3:0] shift,
                            input int first, input int count);
        int          pos;
        logic [31:0] data;
        for (pos = first; pos < first + count; pos++) begin
            data = (pos < 6) ? run_words[pos] : (32'h5a5a_0000 | 32'(pos));
            drive_packet(kind, 16'(WINDOW_START + pos) << shift, shift, data);
        end
        release_bus();
    endtask

    task automatic run_line(input logic [8*LINE_BYTES-1:0] raw);
        logic [7:0]  tag;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        int          n;
        logic        ok;
        ok  = 1'b1;
        tag = line_tag(raw);
        case (tag)
            "P": begin
                n  = $sscanf(raw, " %c %h %h %h %h", tag, a, b, c, d);
                ok = (n == 5);
                if (ok) begin
                    drive_packet(a[1:0], b[15:0], c[3:0], d);
                    release_bus();
                end
            end
            "R": begin
                n  = $sscanf(raw, " %c %h %h %d %d %h %h %h %h %h %h", tag, a, b, c, d,
                             run_words[0], run_words[1], run_words[2], run_words[3],
                             run_words[4], run_words[5]);
                ok = (n == 11);
                if (ok) begin
                    send_run(a[1:0], b[3:0], c, d);
                end
            end
            "C": begin
                n  = $sscanf(raw, " %c %d %d", tag, a, b);
                ok = (n == 3);
                if (ok) begin
                    @(negedge ap_clk);
                    config_ready      = a[0];
                    response_drain_en = b[0];
                end
            end
            // Wait until every configuration announced so far has come out
            "S": wait (u_checker.seen_count >= expects_passed);
            "E": expects_passed++;
            default: begin
            end
        endcase
        if (!ok) begin
            $display("Error: vector line of kind %c is malformed", tag);
            vector_errors++;
        end
    endtask

    // ----------------------------------------------------------
    // Main flow
    // ----------------------------------------------------------
    initial begin : main_flow
        int active_lines;
        seed               = 32'h5b38;
        response_in_valid  = 1'b0;
        response_in_buffer = alu_ops_pkg::STRUCT_INVALID;
        response_in_offset = '0;
        response_in_shift  = '0;
        response_in_data   = '0;
        response_drain_en  = 1'b1;
        config_ready       = 1'b1;
        active_lines       = 0;
        load_vectors();
        foreach (lines[i]) begin
            if (line_tag(lines[i]) != "#") begin
                active_lines++;
            end
            if (line_tag(lines[i]) == "E") begin
                register_expect(lines[i]);
            end
        end
        watchdog_cycles = CYCLES_PER_LINE * active_lines + BASE_CYCLES;
        wait (areset_alu_ops_generator === 1'b1);
        wait (areset_alu_ops_generator === 1'b0);
        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        wait (u_checker.seen_count >= u_checker.expected_total);
        // Room for any extra output to show up
        repeat (SETTLE_CYCLES) @(negedge ap_clk);
        u_checker.report(vector_errors);
        if ((vector_errors == 0) && (u_checker.error_total == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge ap_clk);
        $display("Error: timeout, the run did not finish within %0d cycles", watchdog_cycles);
        u_checker.report(vector_errors);
        $display("Verification failed");
        $finish;
    end

endmodule : tb_engine_alu_ops_configure_memory

// ==== sim/alu_ops_vectors.txt ====
# P kind offset shift data | R kind shift first count w0..w5 (run positions first.. of 16)
# C config_ready drain_en | S wait for all announced outputs | kind 0 inv 1 cu 2 eng 3 other
# E name op alu_mask const_mask const_value ops_mask module engine cu bundle lane buffer
C 1 1
E decode 5 6 9 cafe1234 a5c3 3 2 0 1 2 7
R 2 0 0 16 0000000d 000000b6 0000fff9 cafe1234 1234a5c3 000001e4
E filter 2 f 3 0badf00d 0f0f 0 1 3 2 2 0
R 2 0 0 3 00000002 0000004f 00000003 0badf00d 00000f0f 0000002b
P 3 0013 0 11111111
P 0 0014 0 22222222
R 2 0 3 7 00000002 0000004f 00000003 0badf00d 00000f0f 0000002b
P 2 000f 0 33333333
P 1 0020 0 44444444
R 2 0 10 6 00000002 0000004f 00000003 0badf00d 00000f0f 0000002b
E shift 5 6 9 cafe1234 a5c3 3 2 0 1 2 7
R 1 2 0 16 0000000d 000000b6 0000fff9 cafe1234 1234a5c3 000001e4
E run_start 7 0 c ffffffff 0001 0 3 1 1 1 5
P 2 0011 0 aaaa0001
P 2 001f 0 aaaa0002
R 2 0 0 16 00000007 000000c0 0000000c ffffffff ffff0001 00000155
S
C 0 1
E bp_a 1 1 1 00000001 0001 1 0 1 0 0 1
E bp_b 3 2 2 00000002 0002 2 1 0 2 0 2
E bp_c 4 4 4 00000003 0004 3 3 0 0 3 3
R 2 0 0 16 00000001 00000011 00000001 00000001 00000001 00000041
R 1 0 0 16 00000003 00000062 00000002 00000002 00000002 00000088
R 2 0 0 16 00000004 000000f4 00000004 00000003 00000004 000000f0
C 1 1
S
C 1 0
E bp_drain 6 8 8 deadbeef 8000 2 0 3 3 3 7
R 2 0 0 16 00000006 00000028 00000008 deadbeef 00008000 000001ff
C 1 1

// ==== list.f ====
logic/alu_ops_pkg.sv
logic/sync_fifo.sv
logic/config_response_filter.sv
logic/alu_ops_sequence_assembler.sv
logic/engine_alu_ops_configure_memory.sv
sim/tb_clock_gen.sv
sim/tb_config_checker.sv
sim/tb_engine_alu_ops_configure_memory.sv

// ==== Bender.yml ====
package:
  name: engine_alu_ops_configure_memory

sources:
  - logic/alu_ops_pkg.sv
  - logic/sync_fifo.sv
  - logic/config_response_filter.sv
  - logic/alu_ops_sequence_assembler.sv
  - logic/engine_alu_ops_configure_memory.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_config_checker.sv
      - sim/tb_engine_alu_ops_configure_memory.sv
